/* session_cases.txt */
// kind host type validity init_msg msg_type comp_id comp_len disc disc_host ignore seq seq_host
// kind 0 cfg, 1 rx, 2 resend_done, 3 connect, 4 logout_req, 5 timeout, 6 rx+timeout, f end
0 1 0 0 1 0 42524F4B45523031 8 0 0 0 0 0
0 2 0 0 0 0 0000004558434847 5 0 0 0 0 0
0 3 0 0 0 0 000056454E554533 6 0 0 0 0 0
3 1 0 0 1 1 42524F4B45523031 8 0 0 0 0 0
5 1 0 0 0 0 0000000000000000 0 1 1 0 0 0
3 2 0 0 0 0 0000000000000000 0 0 0 0 0 0
3 3 0 0 0 0 0000000000000000 0 0 0 0 0 0
1 2 1 0 1 1 0000004558434847 5 0 0 0 0 0
1 3 1 2 1 4 000056454E554533 6 0 0 0 0 0
1 2 3 0 1 3 0000004558434847 5 0 0 0 0 0
1 3 5 0 0 0 0000000000000000 0 0 0 0 1 3
1 2 7 1 0 0 0000000000000000 0 0 0 1 0 0
2 3 0 0 0 0 0000000000000000 0 0 0 0 0 0
5 3 0 0 1 3 000056454E554533 6 0 0 0 0 0
4 3 0 0 1 2 000056454E554533 6 0 0 0 0 0
1 3 2 0 0 0 0000000000000000 0 1 3 0 0 0
3 1 0 0 1 1 42524F4B45523031 8 0 0 0 0 0
1 1 1 0 0 0 0000000000000000 0 0 0 0 0 0
1 1 2 2 1 4 42524F4B45523031 8 0 0 0 0 0
2 1 0 0 1 2 42524F4B45523031 8 0 0 0 0 0
6 1 7 1 0 0 0000000000000000 0 0 0 1 0 0
1 1 7 4 0 0 0000000000000000 0 1 1 0 0 0
1 2 7 3 0 0 0000000000000000 0 1 2 0 0 0
1 2 7 0 0 0 0000000000000000 0 0 0 1 0 0
f 0 0 0 0 0 0000000000000000 0 0 0 0 0 0

/* all.f */
+incdir+.
fix_msg_pkg.sv
fix_session_pkg.sv
fix_session_if.sv
host_table.sv
session_table.sv
session_manager.sv
fix_session_top.sv
fix_session_checker.sv
tb_fix_session.sv

/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_fix_session -Mdir obj_dir -f all.f

run: compile
	./obj_dir/Vtb_fix_session > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_fix_session.sv */
/*
  testbench for the FIX session layer
  replays configuration and event cases from a data file and
  checks every output strobe and data output of the DUT
*/
`timescale 1ns/1ps
`include "fix_cfg.svh"

module tb_fix_session;
	import fix_msg_pkg::*;
	import fix_session_pkg::*;

	localparam int COLS       = 13;  // words per case line
	localparam int MAX_CASES  = 64;
	localparam int RST_CYCLES = 5;

	logic      clk = 1'b0;
	logic      rst;
	logic      cfg_we;
	host_id_t  cfg_host;
	comp_id_t  cfg_comp_id;
	comp_len_t cfg_comp_len;
	logic      cfg_initiator;
	logic      rx_msg;
	logic      resend_done;
	logic      connect;
	logic      logout_req;
	logic      timeout;
	host_id_t  host;
	msg_type_t msg_type;
	validity_t validity;

	logic      initiate_msg;
	msg_type_t sent_type;
	comp_id_t  target_comp_id;
	comp_len_t comp_len;
	logic      disconnect;
	host_id_t  disconnect_host;
	logic      ignore;
	logic      seq_update;
	host_id_t  seq_host;

	logic [`FIX_COMP_ID_W-1:0] case_mem [0:MAX_CASES*COLS-1];
	int   num_cases;
	int   limit_cycles = 0;
	int   idx;
	logic found_end;

	fix_session_top dut_i (
		.clk               (clk),
		.rst               (rst),
		.cfg_we_i          (cfg_we),
		.cfg_host_i        (cfg_host),
		.cfg_comp_id_i     (cfg_comp_id),
		.cfg_comp_len_i    (cfg_comp_len),
		.cfg_initiator_i   (cfg_initiator),
		.rx_msg_i          (rx_msg),
		.resend_done_i     (resend_done),
		.connect_i         (connect),
		.logout_req_i      (logout_req),
		.timeout_i         (timeout),
		.host_i            (host),
		.msg_type_i        (msg_type),
		.validity_i        (validity),
		.initiate_msg_o    (initiate_msg),
		.msg_type_o        (sent_type),
		.target_comp_id_o  (target_comp_id),
		.comp_len_o        (comp_len),
		.disconnect_o      (disconnect),
		.disconnect_host_o (disconnect_host),
		.ignore_o          (ignore),
		.seq_update_o      (seq_update),
		.seq_host_o        (seq_host)
	);

	always #20 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("Mismatch at %0t: %s expected %h, got %h",
				$time, name, expected, actual));
		end
	endtask

	// expected values sit in columns 4 to 12 of the case line
	task automatic check_outputs(input int base);
		check_value("initiate_msg_o", case_mem[base+4], 64'(initiate_msg));
		check_value("msg_type_o", case_mem[base+5], 64'(sent_type));
		check_value("target_comp_id_o", case_mem[base+6], 64'(target_comp_id));
		check_value("comp_len_o", case_mem[base+7], 64'(comp_len));
		check_value("disconnect_o", case_mem[base+8], 64'(disconnect));
		check_value("disconnect_host_o", case_mem[base+9], 64'(disconnect_host));
		check_value("ignore_o", case_mem[base+10], 64'(ignore));
		check_value("seq_update_o", case_mem[base+11], 64'(seq_update));
		check_value("seq_host_o", case_mem[base+12], 64'(seq_host));
	endtask

	task automatic drive_case(input int base);
		logic [3:0] kind;
		kind = case_mem[base][3:0];
		@(posedge clk);
		host     <= case_mem[base+1][`FIX_HOST_W-1:0];
		msg_type <= case_mem[base+2][3:0];
		validity <= case_mem[base+3][2:0];
		case (kind)
		4'd0: begin
			cfg_we        <= 1'b1;
			cfg_host      <= case_mem[base+1][`FIX_HOST_W-1:0];
			cfg_comp_id   <= case_mem[base+6];
			cfg_comp_len  <= case_mem[base+7][`FIX_COMP_LEN_W-1:0];
			cfg_initiator <= case_mem[base+4][0];
		end
		4'd1: rx_msg <= 1'b1;
		4'd2: resend_done <= 1'b1;
		4'd3: connect <= 1'b1;
		4'd4: logout_req <= 1'b1;
		4'd5: timeout <= 1'b1;
		4'd6: begin
			rx_msg  <= 1'b1;  // priority case, timeout must be dropped
			timeout <= 1'b1;
		end
		default: abort_run($sformatf("unknown event kind %0h in the case file", kind));
		endcase
		@(posedge clk);
		cfg_we      <= 1'b0;
		rx_msg      <= 1'b0;
		resend_done <= 1'b0;
		connect     <= 1'b0;
		logout_req  <= 1'b0;
		timeout     <= 1'b0;
		if (kind != 4'd0) begin
			@(negedge clk);  // outputs of the event are stable here
			check_outputs(base);
		end
	endtask

	initial begin
		rst           <= 1'b1;
		cfg_we        <= 1'b0;
		cfg_host      <= '0;
		cfg_comp_id   <= '0;
		cfg_comp_len  <= '0;
		cfg_initiator <= 1'b0;
		rx_msg        <= 1'b0;
		resend_done   <= 1'b0;
		connect       <= 1'b0;
		logout_req    <= 1'b0;
		timeout       <= 1'b0;
		host          <= '0;
		msg_type      <= '0;
		validity      <= '0;
		$readmemh("session_cases.txt", case_mem);
		num_cases = 0;
		found_end = 1'b0;
		while (!found_end && num_cases < MAX_CASES) begin
			if (case_mem[num_cases*COLS][3:0] == 4'hf) begin
				found_end = 1'b1;
			end else begin
				num_cases++;
			end
		end
		if (!found_end) begin
			abort_run("case file is missing, unreadable or has no end line");
		end
		limit_cycles = num_cases * 3 + RST_CYCLES;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (idx = 0; idx < num_cases; idx++) begin
			drive_case(idx * COLS);
		end
		$display("Result: PASSED");
		$finish;
	end

	// three cycles per case line plus reset
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		abort_run("watchdog expired before all cases were run");
	end

endmodule

/* fix_session_checker.sv */
/*
  session layer output checker
  reset quiet, one strobe at a time, idle data outputs
*/
`timescale 1ns/1ps

module fix_session_checker (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        initiate_msg_i,
	input  fix_msg_pkg::msg_type_t      msg_type_i,
	input  fix_session_pkg::comp_id_t   target_comp_id_i,
	input  fix_session_pkg::comp_len_t  comp_len_i,
	input  logic                        disconnect_i,
	input  fix_session_pkg::host_id_t   disconnect_host_i,
	input  logic                        ignore_i,
	input  logic                        seq_update_i,
	input  fix_session_pkg::host_id_t   seq_host_i
);

	logic [3:0] strobes;
	logic       all_zero;

	assign strobes  = {initiate_msg_i, disconnect_i, ignore_i, seq_update_i};
	assign all_zero = (strobes == 4'b0) && (msg_type_i == '0) && (target_comp_id_i == '0)
		&& (comp_len_i == '0) && (disconnect_host_i == '0) && (seq_host_i == '0);

	// covers the cycle under reset and the first one after it
	reset_quiet: assert property (@(posedge clk) !rst && ($past(rst) || $past(rst, 2)) |-> all_zero)
		else $error("outputs not zero right after reset");

	one_strobe: assert property (@(posedge clk) disable iff (rst) $onehot0(strobes))
		else $error("more than one output strobe high");

	msg_idle: assert property (@(posedge clk) disable iff (rst)
		!initiate_msg_i |-> (msg_type_i == '0 && target_comp_id_i == '0 && comp_len_i == '0))
		else $error("message data not zero while initiate_msg is low");

	host_idle: assert property (@(posedge clk) disable iff (rst)
		(!disconnect_i |-> disconnect_host_i == '0) and (!seq_update_i |-> seq_host_i == '0))
		else $error("host output not zero while its strobe is low");

endmodule

bind fix_session_top fix_session_checker checker_i (
	.clk               (clk),
	.rst               (rst),
	.initiate_msg_i    (initiate_msg_o),
	.msg_type_i        (msg_type_o),
	.target_comp_id_i  (target_comp_id_o),
	.comp_len_i        (comp_len_o),
	.disconnect_i      (disconnect_o),
	.disconnect_host_i (disconnect_host_o),
	.ignore_i          (ignore_o),
	.seq_update_i      (seq_update_o),
	.seq_host_i        (seq_host_o)
);

/* fix_session_top.sv */
/*
  FIX session layer top
  host configuration table, session state table and session manager
*/
`timescale 1ns/1ps

module fix_session_top (
	input  logic                        clk,
	input  logic                        rst,
	// host configuration
	input  logic                        cfg_we_i,
	input  fix_session_pkg::host_id_t   cfg_host_i,
	input  fix_session_pkg::comp_id_t   cfg_comp_id_i,
	input  fix_session_pkg::comp_len_t  cfg_comp_len_i,
	input  logic                        cfg_initiator_i,
	// events, one strobe served per cycle
	input  logic                        rx_msg_i,
	input  logic                        resend_done_i,
	input  logic                        connect_i,
	input  logic                        logout_req_i,
	input  logic                        timeout_i,
	input  fix_session_pkg::host_id_t   host_i,
	input  fix_msg_pkg::msg_type_t      msg_type_i,
	input  fix_msg_pkg::validity_t      validity_i,
	// to message builder, tcp engine and sequence generator
	output logic                        initiate_msg_o,
	output fix_msg_pkg::msg_type_t      msg_type_o,
	output fix_session_pkg::comp_id_t   target_comp_id_o,
	output fix_session_pkg::comp_len_t  comp_len_o,
	output logic                        disconnect_o,
	output fix_session_pkg::host_id_t   disconnect_host_o,
	output logic                        ignore_o,
	output logic                        seq_update_o,
	output fix_session_pkg::host_id_t   seq_host_o
);

	host_lookup_if   lookup_if ();
	session_table_if tbl_if ();

	host_table host_table_i (
		.clk             (clk),
		.rst             (rst),
		.cfg_we_i        (cfg_we_i),
		.cfg_host_i      (cfg_host_i),
		.cfg_comp_id_i   (cfg_comp_id_i),
		.cfg_comp_len_i  (cfg_comp_len_i),
		.cfg_initiator_i (cfg_initiator_i),
		.lookup          (lookup_if)
	);

	session_table session_table_i (
		.clk (clk),
		.rst (rst),
		.tbl (tbl_if)
	);

	session_manager session_manager_i (
		.clk               (clk),
		.rst               (rst),
		.rx_msg_i          (rx_msg_i),
		.resend_done_i     (resend_done_i),
		.connect_i         (connect_i),
		.logout_req_i      (logout_req_i),
		.timeout_i         (timeout_i),
		.host_i            (host_i),
		.msg_type_i        (msg_type_i),
		.validity_i        (validity_i),
		.lookup            (lookup_if),
		.tbl               (tbl_if),
		.initiate_msg_o    (initiate_msg_o),
		.msg_type_o        (msg_type_o),
		.target_comp_id_o  (target_comp_id_o),
		.comp_len_o        (comp_len_o),
		.disconnect_o      (disconnect_o),
		.disconnect_host_o (disconnect_host_o),
		.ignore_o          (ignore_o),
		.seq_update_o      (seq_update_o),
		.seq_host_o        (seq_host_o)
	);

endmodule

/* session_manager.sv */
/*
  FIX session manager
  picks one event per cycle, runs the per-host session FSM and
  issues registered message, disconnect, ignore and sequence strobes
*/
`timescale 1ns/1ps

module session_manager (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        rx_msg_i,
	input  logic                        resend_done_i,
	input  logic                        connect_i,
	input  logic                        logout_req_i,
	input  logic                        timeout_i,
	input  fix_session_pkg::host_id_t   host_i,
	input  fix_msg_pkg::msg_type_t      msg_type_i,
	input  fix_msg_pkg::validity_t      validity_i,
	host_lookup_if.requester            lookup,
	session_table_if.controller         tbl,
	output logic                        initiate_msg_o,
	output fix_msg_pkg::msg_type_t      msg_type_o,
	output fix_session_pkg::comp_id_t   target_comp_id_o,
	output fix_session_pkg::comp_len_t  comp_len_o,
	output logic                        disconnect_o,
	output fix_session_pkg::host_id_t   disconnect_host_o,
	output logic                        ignore_o,
	output logic                        seq_update_o,
	output fix_session_pkg::host_id_t   seq_host_o
);
	import fix_msg_pkg::*;
	import fix_session_pkg::*;

	session_state_t cur_state;
	session_state_t next_state;
	logic           send_c;
	msg_type_t      send_type_c;
	logic           disc_c;
	logic           ign_c;
	logic           seq_c;
	logic           fatal;

	// every event uses the same host, so both lookups share it
	assign lookup.host = host_i;
	assign tbl.addr    = host_i;
	assign cur_state   = tbl.rdata;

	assign fatal = (validity_i == val_seq_low) || (validity_i == val_invalid);

	// state is rewritten for every served event, often unchanged
	assign tbl.we    = rx_msg_i | resend_done_i | connect_i | logout_req_i | timeout_i;
	assign tbl.wdata = next_state;

	// fixed priority: rx_msg, resend_done, connect, logout_req, timeout
	always_comb begin
		send_c      = 1'b0;
		send_type_c = msg_none;
		disc_c      = 1'b0;
		ign_c       = 1'b0;
		seq_c       = 1'b0;
		next_state  = cur_state;

		if (rx_msg_i) begin
			if (fatal) begin
				disc_c     = 1'b1;
				next_state = st_disconnected;
			end else begin
				case (cur_state)
				st_disconnected: ign_c = 1'b1;
				st_await_logon, st_logon_sent: begin
					if (msg_type_i == msg_logon && validity_i == val_valid) begin
						send_c      = (cur_state == st_await_logon);  // acceptor answers
						send_type_c = msg_logon;
						next_state  = st_active;
					end else if (msg_type_i == msg_logon && validity_i == val_seq_high) begin
						send_c      = 1'b1;
						send_type_c = msg_resend_req;
						next_state  = st_resend_pending;
					end else begin
						disc_c     = 1'b1;
						next_state = st_disconnected;
					end
				end
				st_active, st_heartbeat_sent: begin
					if (validity_i == val_garbled) begin
						ign_c = 1'b1;
					end else if (msg_type_i == msg_logout && validity_i == val_seq_high) begin
						send_c      = 1'b1;
						send_type_c = msg_resend_req;
						next_state  = st_resend_pending_logout;
					end else if (msg_type_i == msg_logout && validity_i == val_valid) begin
						send_c      = 1'b1;
						send_type_c = msg_logout;
						next_state  = st_disconnected;
					end else if (validity_i == val_seq_high) begin
						send_c      = 1'b1;
						send_type_c = msg_resend_req;
						next_state  = st_resend_pending;
					end else if (msg_type_i == msg_heartbeat && cur_state == st_active) begin
						send_c      = 1'b1;
						send_type_c = msg_heartbeat;
					end else begin
						next_state = st_active;  // peer traffic proves liveness
					end
				end
				st_resend_pending, st_resend_pending_logout: begin
					if (validity_i == val_garbled) begin
						ign_c = 1'b1;
					end else if (msg_type_i == msg_gap_fill || msg_type_i == msg_seq_reset) begin
						seq_c = 1'b1;
					end else if (validity_i == val_seq_high) begin
						send_c      = 1'b1;
						send_type_c = msg_resend_req;
					end
				end
				st_logout_sent: begin
					if (validity_i == val_garbled) begin
						ign_c = 1'b1;
					end else begin
						disc_c     = 1'b1;
						next_state = st_disconnected;
					end
				end
				default: ;
				endcase
			end
		end else if (resend_done_i) begin
			if (cur_state == st_resend_pending) begin
				next_state = st_active;
			end else if (cur_state == st_resend_pending_logout) begin
				send_c      = 1'b1;
				send_type_c = msg_logout;
				next_state  = st_logout_sent;
			end
		end else if (connect_i) begin
			if (lookup.initiator) begin
				send_c      = 1'b1;
				send_type_c = msg_logon;
				next_state  = st_logon_sent;
			end else begin
				next_state = st_await_logon;
			end
		end else if (logout_req_i) begin
			if (cur_state == st_active || cur_state == st_heartbeat_sent) begin
				send_c      = 1'b1;
				send_type_c = msg_logout;
				next_state  = st_logout_sent;
			end
		end else if (timeout_i) begin
			case (cur_state)
			st_logon_sent, st_logout_sent, st_heartbeat_sent: begin
				disc_c     = 1'b1;  // no answer from peer
				next_state = st_disconnected;
			end
			st_active: begin
				send_c      = 1'b1;
				send_type_c = msg_heartbeat;
				next_state  = st_heartbeat_sent;
			end
			default: ;
			endcase
		end
	end

	// data outputs stay zero while their strobe is low
	always_ff @(posedge clk) begin
		if (rst) begin
			initiate_msg_o    <= 1'b0;
			msg_type_o        <= msg_none;
			target_comp_id_o  <= '0;
			comp_len_o        <= '0;
			disconnect_o      <= 1'b0;
			disconnect_host_o <= '0;
			ignore_o          <= 1'b0;
			seq_update_o      <= 1'b0;
			seq_host_o        <= '0;
		end else begin
			initiate_msg_o    <= send_c;
			msg_type_o        <= send_c ? send_type_c : msg_none;
			target_comp_id_o  <= send_c ? lookup.comp_id : '0;
			comp_len_o        <= send_c ? lookup.comp_len : '0;
			disconnect_o      <= disc_c;
			disconnect_host_o <= disc_c ? host_i : '0;
			ignore_o          <= ign_c;
			seq_update_o      <= seq_c;
			seq_host_o        <= seq_c ? host_i : '0;
		end
	end

endmodule

/* session_table.sv */
/*
  session state table
  one session state per host, all hosts start disconnected
*/
`timescale 1ns/1ps
`include "fix_cfg.svh"

module session_table (
	input  logic              clk,
	input  logic              rst,
	session_table_if.memory   tbl
);
	import fix_session_pkg::*;

	session_state_t state_q [`FIX_NUM_HOSTS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FIX_NUM_HOSTS; i++) begin
				state_q[i] <= st_disconnected;
			end
		end else if (tbl.we) begin
			state_q[tbl.addr] <= tbl.wdata;  // single write port
		end
	end

	assign tbl.rdata = state_q[tbl.addr];

endmodule

/* host_table.sv */
/*
  host configuration table
  user-written target CompID, length and role per host,
  read combinationally by the session manager
*/
`timescale 1ns/1ps
`include "fix_cfg.svh"

module host_table (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       cfg_we_i,
	input  fix_session_pkg::host_id_t  cfg_host_i,
	input  fix_session_pkg::comp_id_t  cfg_comp_id_i,
	input  fix_session_pkg::comp_len_t cfg_comp_len_i,
	input  logic                       cfg_initiator_i,
	host_lookup_if.responder           lookup
);
	import fix_session_pkg::*;

	comp_id_t  comp_id_q   [`FIX_NUM_HOSTS];
	comp_len_t comp_len_q  [`FIX_NUM_HOSTS];
	logic      initiator_q [`FIX_NUM_HOSTS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FIX_NUM_HOSTS; i++) begin
				comp_id_q[i]   <= '0;
				comp_len_q[i]  <= '0;
				initiator_q[i] <= 1'b0;  // acceptor by default
			end
		end else if (cfg_we_i) begin
			comp_id_q[cfg_host_i]   <= cfg_comp_id_i;
			comp_len_q[cfg_host_i]  <= cfg_comp_len_i;
			initiator_q[cfg_host_i] <= cfg_initiator_i;
		end
	end

	// a write in the same cycle is seen from the next cycle on
	assign lookup.comp_id   = comp_id_q[lookup.host];
	assign lookup.comp_len  = comp_len_q[lookup.host];
	assign lookup.initiator = initiator_q[lookup.host];

endmodule

/* fix_session_if.sv */
/*
  session layer internal buses
  host configuration lookup and session-state table access
*/
`timescale 1ns/1ps

interface host_lookup_if;
	import fix_session_pkg::*;

	host_id_t  host;
	comp_id_t  comp_id;
	comp_len_t comp_len;
	logic      initiator;  // 1 when this side opens the session

	modport requester (output host, input comp_id, comp_len, initiator);
	modport responder (input host, output comp_id, comp_len, initiator);
endinterface

interface session_table_if;
	import fix_session_pkg::*;

	logic           we;
	host_id_t       addr;
	session_state_t wdata;
	session_state_t rdata;  // combinational read of addr

	modport controller (output we, addr, wdata, input rdata);
	modport memory (input we, addr, wdata, output rdata);
endinterface

/* fix_session_pkg.sv */
/*
  FIX session package
  host, CompID and length types plus the per-host session states
*/
`include "fix_cfg.svh"

package fix_session_pkg;

	typedef logic [`FIX_HOST_W-1:0]     host_id_t;
	typedef logic [`FIX_COMP_ID_W-1:0]  comp_id_t;
	typedef logic [`FIX_COMP_LEN_W-1:0] comp_len_t;

	// per-host session state, held in the session table
	typedef enum logic [2:0] {
		st_disconnected         = 3'd0,
		st_await_logon          = 3'd1,  // acceptor, tcp up
		st_logon_sent           = 3'd2,  // initiator, waiting for reply
		st_active               = 3'd3,
		st_heartbeat_sent       = 3'd4,
		st_resend_pending       = 3'd5,
		st_resend_pending_logout = 3'd6, // logout deferred until gap is filled
		st_logout_sent          = 3'd7
	} session_state_t;

endpackage

/* fix_msg_pkg.sv */
/*
  FIX message package
  message-type and validity codes shared by the parser,
  the session layer and the message builder
*/
package fix_msg_pkg;

	// session-level message kinds, everything else is app
	typedef logic [3:0] msg_type_t;

	localparam msg_type_t msg_none       = 4'd0;  // no message, idle output
	localparam msg_type_t msg_logon      = 4'd1;
	localparam msg_type_t msg_logout     = 4'd2;
	localparam msg_type_t msg_heartbeat  = 4'd3;
	localparam msg_type_t msg_resend_req = 4'd4;
	localparam msg_type_t msg_gap_fill   = 4'd5;
	localparam msg_type_t msg_seq_reset  = 4'd6;
	localparam msg_type_t msg_app        = 4'd7;

	// parser verdict on the incoming sequence number and body
	typedef logic [2:0] validity_t;

	localparam validity_t val_valid    = 3'd0;
	localparam validity_t val_garbled  = 3'd1;  // bad checksum or framing
	localparam validity_t val_seq_high = 3'd2;  // gap, ask for resend
	localparam validity_t val_seq_low  = 3'd3;  // fatal
	localparam validity_t val_invalid  = 3'd4;  // fatal

endpackage

/* fix_cfg.svh */
/*
  FIX session layer sizing
  widths of host numbers, target CompIDs and CompID lengths
*/
`ifndef FIX_CFG_SVH
`define FIX_CFG_SVH

`define FIX_HOST_W      4                   // up to 16 remote hosts
`define FIX_NUM_HOSTS   (1 << `FIX_HOST_W)
`define FIX_COMP_ID_W   64                  // eight ascii characters
`define FIX_COMP_LEN_W  4                   // number of valid characters

`endif
